/* build.f */
+incdir+tb
verilog/md5Pkg.sv
verilog/md5Padder.sv
verilog/md5Step.sv
verilog/md5Pipeline.sv
tb/md5Pipeline_chk.sv
tb/md5PipelineTb.sv

/* Bender.yml */
package:
  name: md5_pipeline

sources:
  # RTL
  - files:
      - verilog/md5Pkg.sv
      - verilog/md5Padder.sv
      - verilog/md5Step.sv
      - verilog/md5Pipeline.sv

  # Testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/md5Pipeline_chk.sv
      - tb/md5PipelineTb.sv

/* tb/md5PipelineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module md5PipelineTb;

	localparam int lengthSweep = 16;
	localparam int prefixPairs = 8;
	localparam int randomCount = 400;
	localparam int vectorCount = 3 + lengthSweep + 2 * prefixPairs + randomCount;
	localparam int watchdogNs = (vectorCount + md5Pkg::pipeLatency + 20) * 8;

	logic clk;
	logic reset;
	logic [8*md5Pkg::guessBytes-1:0] guess;
	logic [md5Pkg::guessLenBits-1:0] guessLen;
	md5Pkg::word_t hashA, hashB, hashC, hashD;

	logic [31:0] rngState = 32'd13358;
	int applied = 0;

	md5Pipeline md5Pipeline_i (
		.clk(clk),
		.reset(reset),
		.guess(guess),
		.guessLen(guessLen),
		.hashA(hashA),
		.hashB(hashB),
		.hashC(hashC),
		.hashD(hashD)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function logic [127:0] randomGuess();
		return {nextRand(), nextRand(), nextRand(), nextRand()};
	endfunction

	// One guess per clock with no gaps
	task automatic applyGuess(input logic [127:0] g, input logic [3:0] len);
		@(posedge clk);
		guess <= g;
		guessLen <= len;
		applied++;
	endtask

	initial begin
		logic [127:0] base;
		logic [127:0] keepMask;
		logic [3:0] len;
		logic [31:0] rnd;
		int errors;
		int checks;
		reset = 1'b1;
		guess = '0;
		guessLen = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// Empty string then two known strings
		applyGuess(128'h0, 4'd0);
		applyGuess({"abc", 104'h0}, 4'd3);
		applyGuess({"The quick brown", 8'h00}, 4'd15);

		// Every marker position
		for (int n = 0; n < lengthSweep; n++) begin
			applyGuess(randomGuess(), n[3:0]);
		end

		// Shared prefix and length with differing tail bytes
		for (int p = 0; p < prefixPairs; p++) begin
			base = randomGuess();
			rnd = nextRand();
			len = rnd[19:16];
			keepMask = ~({128{1'b1}} >> (8 * len));
			applyGuess(base, len);
			applyGuess((base & keepMask) | (randomGuess() & ~keepMask), len);
		end

		for (int n = 0; n < randomCount; n++) begin
			rnd = nextRand();
			applyGuess(randomGuess(), rnd[19:16]);
		end

		// Drain the pipe
		repeat (md5Pkg::pipeLatency + 2) @(posedge clk);
		@(negedge clk);

		errors = md5Pipeline_i.chk.failCount;
		checks = md5Pipeline_i.chk.checkCount;
		$display("Vectors applied: %0d, digest checks: %0d, errors: %0d", applied, checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			if (checks == 0) begin
				$display("No digest was ever compared against the model");
			end
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdogNs * 1ns);
		$display("Timeout: the run did not finish within %0d ns", watchdogNs);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/md5Model.svh */
// Behavioral MD5 of one padded block for guesses of 0 to 15 bytes.
// Returns {A, B, C, D} in MD5 word order.
function automatic logic [127:0] md5Digest(input logic [127:0] msg, input logic [3:0] len);
	logic [7:0] blk [0:63];
	logic [31:0] w [0:15];
	logic [4:0] rot [0:15];
	logic [31:0] a, b, c, d, f, k, t;
	logic [4:0] r;
	longint kFull;
	real s;
	int i;
	int g;
	rot = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
	// Build the whole 64-byte block in stream order
	for (i = 0; i < 64; i++) begin
		blk[i] = 8'h00;
	end
	for (i = 0; i < len; i++) begin
		blk[i] = msg[127-8*i -: 8];
	end
	blk[len] = 8'h80;
	// Bit length, low byte of word 14
	blk[56] = {len, 3'b000};
	for (i = 0; i < 16; i++) begin
		w[i] = {blk[4*i+3], blk[4*i+2], blk[4*i+1], blk[4*i]};
	end
	a = md5Pkg::initA;
	b = md5Pkg::initB;
	c = md5Pkg::initC;
	d = md5Pkg::initD;
	for (i = 0; i < 64; i++) begin
		// T[i] = floor(|sin(i+1)| * 2^32)
		s = $sin(i + 1);
		if (s < 0.0) begin
			s = -s;
		end
		kFull = longint'($floor(s * 4294967296.0));
		k = kFull[31:0];
		case (i / 16)
			0: begin
				f = (b & c) | (~b & d);
				g = i;
			end
			1: begin
				f = (d & b) | (~d & c);
				g = (5 * i + 1) % 16;
			end
			2: begin
				f = b ^ c ^ d;
				g = (3 * i + 5) % 16;
			end
			default: begin
				f = c ^ (b | ~d);
				g = (7 * i) % 16;
			end
		endcase
		r = rot[4 * (i / 16) + i % 4];
		t = a + f + k + w[g];
		a = d;
		d = c;
		c = b;
		b = b + ((t << r) | (t >> (32 - r)));
	end
	return {a + md5Pkg::initA, b + md5Pkg::initB, c + md5Pkg::initC, d + md5Pkg::initD};
endfunction

/* tb/md5Pipeline_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module md5Pipeline_chk (
	input logic clk,
	input logic reset,
	input logic [8*md5Pkg::guessBytes-1:0] guess,
	input logic [md5Pkg::guessLenBits-1:0] guessLen,
	input md5Pkg::word_t hashA,
	input md5Pkg::word_t hashB,
	input md5Pkg::word_t hashC,
	input md5Pkg::word_t hashD
);

	`include "md5Model.svh"

	// Expected digests, entry k was taken k+1 edges ago
	logic [127:0] expHash [0:md5Pkg::pipeLatency-1];
	int cycleCount;
	int checkCount = 0;
	int failCount = 0;
	logic armed;
	md5Pkg::word_t expA, expB, expC, expD;

	always_ff @(posedge clk) begin
		if (reset) begin
			cycleCount <= 0;
		end else if (cycleCount <= md5Pkg::pipeLatency) begin
			cycleCount <= cycleCount + 1;
		end
		if (armed && !reset) begin
			checkCount <= checkCount + 1;
		end
		expHash[0] <= md5Digest(guess, guessLen);
		for (int i = 1; i < md5Pkg::pipeLatency; i++) begin
			expHash[i] <= expHash[i-1];
		end
	end

	// Only once the pipe holds post-reset guesses
	assign armed = cycleCount > md5Pkg::pipeLatency;

	assign expA = expHash[md5Pkg::pipeLatency-1][127:96];
	assign expB = expHash[md5Pkg::pipeLatency-1][95:64];
	assign expC = expHash[md5Pkg::pipeLatency-1][63:32];
	assign expD = expHash[md5Pkg::pipeLatency-1][31:0];

	hashAOk: assert property (@(posedge clk) disable iff (reset) armed |-> hashA == expA)
		else begin
			$error("FAIL %0t: hashA %h, expected %h", $time, $sampled(hashA), $sampled(expA));
			failCount++;
		end

	hashBOk: assert property (@(posedge clk) disable iff (reset) armed |-> hashB == expB)
		else begin
			$error("FAIL %0t: hashB %h, expected %h", $time, $sampled(hashB), $sampled(expB));
			failCount++;
		end

	hashCOk: assert property (@(posedge clk) disable iff (reset) armed |-> hashC == expC)
		else begin
			$error("FAIL %0t: hashC %h, expected %h", $time, $sampled(hashC), $sampled(expC));
			failCount++;
		end

	hashDOk: assert property (@(posedge clk) disable iff (reset) armed |-> hashD == expD)
		else begin
			$error("FAIL %0t: hashD %h, expected %h", $time, $sampled(hashD), $sampled(expD));
			failCount++;
		end

	// Outputs cleared on the edge after every reset cycle
	resetClears: assert property (@(posedge clk)
		reset |=> (hashA == '0 && hashB == '0 && hashC == '0 && hashD == '0))
		else begin
			$error("FAIL %0t: hash outputs not zero after reset", $time);
			failCount++;
		end

endmodule

bind md5Pipeline md5Pipeline_chk chk (
	.clk(clk),
	.reset(reset),
	.guess(guess),
	.guessLen(guessLen),
	.hashA(hashA),
	.hashB(hashB),
	.hashC(hashC),
	.hashD(hashD)
);

`default_nettype wire

/* verilog/md5Pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module md5Pipeline (
	input logic clk,
	input logic reset,
	input logic [8*md5Pkg::guessBytes-1:0] guess,
	input logic [md5Pkg::guessLenBits-1:0] guessLen,
	output md5Pkg::word_t hashA,
	output md5Pkg::word_t hashB,
	output md5Pkg::word_t hashC,
	output md5Pkg::word_t hashD
);

	// Index n is the input of step n
	md5Pkg::word_t stA [0:md5Pkg::stepCount];
	md5Pkg::word_t stB [0:md5Pkg::stepCount];
	md5Pkg::word_t stC [0:md5Pkg::stepCount];
	md5Pkg::word_t stD [0:md5Pkg::stepCount];
	md5Pkg::word_t m0 [0:md5Pkg::stepCount];
	md5Pkg::word_t m1 [0:md5Pkg::stepCount];
	md5Pkg::word_t m2 [0:md5Pkg::stepCount];
	md5Pkg::word_t m3 [0:md5Pkg::stepCount];
	md5Pkg::word_t mLen [0:md5Pkg::stepCount];

	md5Padder padder (
		.clk(clk),
		.reset(reset),
		.guess(guess),
		.guessLen(guessLen),
		.msg0(m0[0]),
		.msg1(m1[0]),
		.msg2(m2[0]),
		.msg3(m3[0]),
		.msgLen(mLen[0])
	);

	// Step 0 starts from the initial chaining value
	assign stA[0] = md5Pkg::initA;
	assign stB[0] = md5Pkg::initB;
	assign stC[0] = md5Pkg::initC;
	assign stD[0] = md5Pkg::initD;

	for (genvar i = 0; i < md5Pkg::stepCount; i++) begin : step
		md5Step #(
			.stepIndex(i)
		) u (
			.clk(clk),
			.reset(reset),
			.inA(stA[i]),
			.inB(stB[i]),
			.inC(stC[i]),
			.inD(stD[i]),
			.in0(m0[i]),
			.in1(m1[i]),
			.in2(m2[i]),
			.in3(m3[i]),
			.inLen(mLen[i]),
			.outA(stA[i+1]),
			.outB(stB[i+1]),
			.outC(stC[i+1]),
			.outD(stD[i+1]),
			.out0(m0[i+1]),
			.out1(m1[i+1]),
			.out2(m2[i+1]),
			.out3(m3[i+1]),
			.outLen(mLen[i+1])
		);
	end

	// Final feed-forward of the chaining value
	always_ff @(posedge clk) begin
		if (reset) begin
			hashA <= '0;
			hashB <= '0;
			hashC <= '0;
			hashD <= '0;
		end else begin
			hashA <= stA[md5Pkg::stepCount] + md5Pkg::initA;
			hashB <= stB[md5Pkg::stepCount] + md5Pkg::initB;
			hashC <= stC[md5Pkg::stepCount] + md5Pkg::initC;
			hashD <= stD[md5Pkg::stepCount] + md5Pkg::initD;
		end
	end

endmodule

`default_nettype wire

/* verilog/md5Step.sv */
`timescale 1ns/1ps
`default_nettype none

module md5Step #(
	parameter int stepIndex = 0
) (
	input logic clk,
	input logic reset,
	input md5Pkg::word_t inA,
	input md5Pkg::word_t inB,
	input md5Pkg::word_t inC,
	input md5Pkg::word_t inD,
	input md5Pkg::word_t in0,
	input md5Pkg::word_t in1,
	input md5Pkg::word_t in2,
	input md5Pkg::word_t in3,
	input md5Pkg::word_t inLen,
	output md5Pkg::word_t outA,
	output md5Pkg::word_t outB,
	output md5Pkg::word_t outC,
	output md5Pkg::word_t outD,
	output md5Pkg::word_t out0,
	output md5Pkg::word_t out1,
	output md5Pkg::word_t out2,
	output md5Pkg::word_t out3,
	output md5Pkg::word_t outLen
);

	localparam md5Pkg::stepFunc_t func = md5Pkg::stepFuncOf(stepIndex);
	localparam logic [4:0] shift = md5Pkg::shiftOf(stepIndex);
	localparam md5Pkg::word_t stepConst = md5Pkg::constOf(stepIndex);
	localparam int msgIndex = md5Pkg::msgIndexOf(stepIndex);

	md5Pkg::word_t roundVal;
	md5Pkg::word_t msgWord;
	md5Pkg::word_t inner;
	logic [2*md5Pkg::wordBits-1:0] funnel;
	md5Pkg::word_t rotated;

	always_comb begin
		case (func)
			md5Pkg::funcF: roundVal = (inB & inC) | (~inB & inD);
			md5Pkg::funcG: roundVal = (inB & inD) | (inC & ~inD);
			md5Pkg::funcH: roundVal = inB ^ inC ^ inD;
			default: roundVal = inC ^ (inB | ~inD);
		endcase
	end

	// Words 4 to 13 and 15 are zero for guesses under 16 bytes
	always_comb begin
		case (msgIndex)
			0: msgWord = in0;
			1: msgWord = in1;
			2: msgWord = in2;
			3: msgWord = in3;
			14: msgWord = inLen;
			default: msgWord = '0;
		endcase
	end

	assign inner = inA + roundVal + msgWord + stepConst;

	// Left rotate via a doubled word
	assign funnel = {inner, inner} << shift;
	assign rotated = funnel[2*md5Pkg::wordBits-1 -: md5Pkg::wordBits];

	always_ff @(posedge clk) begin
		if (reset) begin
			outA <= '0;
			outB <= '0;
			outC <= '0;
			outD <= '0;
			out0 <= '0;
			out1 <= '0;
			out2 <= '0;
			out3 <= '0;
			outLen <= '0;
		end else begin
			outA <= inD;
			outB <= inB + rotated;
			outC <= inB;
			outD <= inC;
			// Message words travel alongside the state
			out0 <= in0;
			out1 <= in1;
			out2 <= in2;
			out3 <= in3;
			outLen <= inLen;
		end
	end

endmodule

`default_nettype wire

/* verilog/md5Padder.sv */
`timescale 1ns/1ps
`default_nettype none

module md5Padder (
	input logic clk,
	input logic reset,
	input logic [8*md5Pkg::guessBytes-1:0] guess,
	input logic [md5Pkg::guessLenBits-1:0] guessLen,
	output md5Pkg::word_t msg0,
	output md5Pkg::word_t msg1,
	output md5Pkg::word_t msg2,
	output md5Pkg::word_t msg3,
	output md5Pkg::word_t msgLen
);

	// Padded message bytes in stream order
	logic [7:0] padBytes [0:md5Pkg::guessBytes-1];

	always_comb begin
		int k;
		for (k = 0; k < md5Pkg::guessBytes; k++) begin
			if (k < guessLen) begin
				// First guess byte sits in the top bits
				padBytes[k] = guess[8*(md5Pkg::guessBytes-1-k) +: 8];
			end else if (k == guessLen) begin
				padBytes[k] = 8'h80;
			end else begin
				padBytes[k] = 8'h00;
			end
		end
	end

	// Little-endian packing, first byte in the low bits of each word
	always_ff @(posedge clk) begin
		if (reset) begin
			msg0 <= '0;
			msg1 <= '0;
			msg2 <= '0;
			msg3 <= '0;
			msgLen <= '0;
		end else begin
			msg0 <= {padBytes[3], padBytes[2], padBytes[1], padBytes[0]};
			msg1 <= {padBytes[7], padBytes[6], padBytes[5], padBytes[4]};
			msg2 <= {padBytes[11], padBytes[10], padBytes[9], padBytes[8]};
			msg3 <= {padBytes[15], padBytes[14], padBytes[13], padBytes[12]};
			// Length in bits
			msgLen <= md5Pkg::word_t'(guessLen) << 3;
		end
	end

endmodule

`default_nettype wire

/* verilog/md5Pkg.sv */
`default_nettype none

package md5Pkg;

	// Word and field widths
	localparam int wordBits = 32;
	localparam int guessBytes = 16;
	localparam int guessLenBits = 4;

	typedef logic [wordBits-1:0] word_t;

	// Pipeline depth: padder, one stage per step, output adder
	localparam int stepCount = 64;
	localparam int pipeLatency = stepCount + 2;

	// Initial chaining value
	localparam word_t initA = 32'h67452301;
	localparam word_t initB = 32'hefcdab89;
	localparam word_t initC = 32'h98badcfe;
	localparam word_t initD = 32'h10325476;

	typedef enum logic [1:0] {
		funcF,
		funcG,
		funcH,
		funcI
	} stepFunc_t;

	// Rotate amounts, four per round
	localparam logic [4:0] shiftTable [0:15] = '{
		5'd7, 5'd12, 5'd17, 5'd22,
		5'd5, 5'd9, 5'd14, 5'd20,
		5'd4, 5'd11, 5'd16, 5'd23,
		5'd6, 5'd10, 5'd15, 5'd21
	};

	// Sine-derived additive constants
	localparam word_t constTable [0:63] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	// One round function per group of sixteen steps
	function automatic stepFunc_t stepFuncOf(input int stepIdx);
		case (stepIdx / 16)
			0: return funcF;
			1: return funcG;
			2: return funcH;
			default: return funcI;
		endcase
	endfunction

	function automatic logic [4:0] shiftOf(input int stepIdx);
		return shiftTable[4 * (stepIdx / 16) + stepIdx % 4];
	endfunction

	function automatic word_t constOf(input int stepIdx);
		return constTable[stepIdx];
	endfunction

	// Block word consumed by each step
	function automatic int msgIndexOf(input int stepIdx);
		case (stepIdx / 16)
			0: return stepIdx % 16;
			1: return (5 * stepIdx + 1) % 16;
			2: return (3 * stepIdx + 5) % 16;
			default: return (7 * stepIdx) % 16;
		endcase
	endfunction

endpackage

`default_nettype wire
